/* debug_subsystem.f */
logic/debug_pkg.sv
logic/jtag_tap.sv
logic/dm_regs.sv
logic/sba_obi_master.sv
logic/debug_subsystem.sv
verif/tb_debug_subsystem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_debug_subsystem
FILELIST  := debug_subsystem.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: PASS"; \
	else \
		echo "Result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_debug_subsystem.sv */
/*
 * Testbench for the debug subsystem. Drives JTAG scans from a step table,
 * models an OBI memory on the bus port and a core on the data0 window.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_debug_subsystem
  import debug_pkg::*;
();

  localparam word_t TB_IDCODE = 32'h249511c3;
  localparam int TCK_HALF = 8;      // System clocks per TCK phase.
  localparam int WAIT_LIMIT = 64;
  localparam int POLL_LIMIT = 20;

  localparam logic [2:0] K_DMI = 3'd0;
  localparam logic [2:0] K_PINS = 3'd1;   // exp[1:0] holds {ndmreset_no, core_req}.
  localparam logic [2:0] K_POLL = 3'd2;
  localparam logic [2:0] K_MEM = 3'd3;    // wdata holds the word index.
  localparam logic [2:0] K_CORE_WR = 3'd4;  // mask[3:0] holds the byte enables.
  localparam logic [2:0] K_CORE_RD = 3'd5;

  typedef struct packed {
    logic [2:0] kind;
    logic [1:0] op;
    dmi_addr_t  addr;
    word_t      wdata;
    word_t      exp;
    word_t      mask;
  } step_t;

  logic      clk, reset;
  logic      tck, tms, tdi;
  wire       tdo;
  wire       ndmreset_n, core_req;
  obi_req_t  slave_req, master_req;
  obi_resp_t slave_resp, master_resp;

  word_t  mem [16];
  int     grant_delay, wait_cnt;
  logic   rvalid_pending;
  word_t  rdata_pending;
  logic [3:0] idx;
  integer seed = 32'h69efd741;
  int     errors, checks;
  step_t  steps [$];

  debug_subsystem #(
    .jtag_idcode(TB_IDCODE)
  ) debug_subsystem_i (
    .clk_i              (clk),
    .reset_i            (reset),
    .jtag_tck_i         (tck),
    .jtag_tms_i         (tms),
    .jtag_tdi_i         (tdi),
    .jtag_tdo_o         (tdo),
    .debug_ndmreset_no  (ndmreset_n),
    .debug_core_req_o   (core_req),
    .debug_slave_req_i  (slave_req),
    .debug_slave_resp_o (slave_resp),
    .debug_master_req_o (master_req),
    .debug_master_resp_i(master_resp)
  );

  always #2 clk = ~clk;

  function automatic word_t fill_word(input int i);
    return 32'h5a5a0000 ^ (word_t'(i) * 32'h01010101);
  endfunction

  // Memory model. Grants after a random delay, read data follows one cycle later.
  always @(negedge clk) begin
    master_resp.gnt = 1'b0;
    master_resp.rvalid = 1'b0;
    if (reset) begin
      rvalid_pending = 1'b0;
      wait_cnt = 0;
    end else begin
      if (rvalid_pending) begin
        master_resp.rvalid = 1'b1;
        master_resp.rdata = rdata_pending;
        rvalid_pending = 1'b0;
      end
      if (master_req.req) begin
        if (wait_cnt >= grant_delay) begin
          master_resp.gnt = 1'b1;
          idx = master_req.addr[5:2];
          if (master_req.we) begin
            for (int b = 0; b < 4; b++) begin
              if (master_req.be[b]) mem[idx][8*b +: 8] = master_req.wdata[8*b +: 8];
            end
          end
          rdata_pending = mem[idx];
          rvalid_pending = 1'b1;
          wait_cnt = 0;
          grant_delay = $random(seed) & 32'h3;
        end else begin
          wait_cnt++;
        end
      end
    end
  end

  task automatic check_value(input string name, input word_t exp, input word_t act,
                             input word_t mask);
    checks++;
    if ((act & mask) !== (exp & mask)) begin
      errors++;
      $display("ERROR: %s expected 0x%08h got 0x%08h", name, exp & mask, act & mask);
    end
  endtask

  // One TCK period. TDO is sampled at the end of the low phase.
  task automatic tck_tick(input logic tms_v, input logic tdi_v, output logic tdo_v);
    tck = 1'b0;
    tms = tms_v;
    tdi = tdi_v;
    repeat (TCK_HALF) @(negedge clk);
    tdo_v = tdo;
    tck = 1'b1;
    repeat (TCK_HALF) @(negedge clk);
  endtask

  task automatic tap_reset();
    logic unused;
    repeat (5) tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);  // Run-Test/Idle.
  endtask

  task automatic ir_scan(input logic [4:0] ir);
    logic unused;
    tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);
    for (int i = 0; i < 5; i++) begin
      tck_tick(i == 4, ir[i], unused);
    end
    tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);
  endtask

  task automatic dr_scan(input int len, input logic [40:0] din, output logic [40:0] dout);
    logic unused;
    dout = '0;
    tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);
    for (int i = 0; i < len; i++) begin
      tck_tick(i == len - 1, din[i], dout[i]);
    end
    tck_tick(1'b1, 1'b0, unused);
    tck_tick(1'b0, 1'b0, unused);  // Update-DR issues the request here.
  endtask

  task automatic dmi_write(input dmi_addr_t addr, input word_t data);
    logic [40:0] unused;
    dr_scan(41, {addr, data, DMI_WRITE}, unused);
  endtask

  // The response of a read shows up in the capture of the following NOP scan.
  task automatic dmi_read(input dmi_addr_t addr, output word_t data, output logic [1:0] op);
    logic [40:0] dout;
    dr_scan(41, {addr, 32'h0, DMI_READ}, dout);
    dr_scan(41, {7'h00, 32'h0, DMI_NOP}, dout);
    data = dout[33:2];
    op = dout[1:0];
  endtask

  task automatic poll_sbbusy();
    word_t sbcs;
    logic [1:0] op;
    int n;
    n = 0;
    sbcs = 32'h00200000;
    while (sbcs[21] && n < POLL_LIMIT) begin
      dmi_read(ADDR_SBCS, sbcs, op);
      n++;
    end
    if (sbcs[21]) begin
      errors++;
      $display("Timeout: sbbusy still set after %0d polls of sbcs", n);
    end
  endtask

  task automatic wait_pins(input logic [1:0] exp);
    int n;
    n = 0;
    while ({ndmreset_n, core_req} !== exp && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    check_value("debug_core_req_o", {31'b0, exp[0]}, {31'b0, core_req}, 32'h1);
    check_value("debug_ndmreset_no", {31'b0, exp[1]}, {31'b0, ndmreset_n}, 32'h1);
  endtask

  task automatic core_access(input logic we, input logic [3:0] be, input word_t wdata,
                             output word_t rdata);
    int n;
    n = 0;
    slave_req = '{req: 1'b1, we: we, be: be, addr: 32'h0000_0040, wdata: wdata};
    @(negedge clk);
    while (!slave_resp.gnt && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    slave_req.req = 1'b0;
    while (!slave_resp.rvalid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT) begin
      errors++;
      $display("Timeout: core access on the OBI slave port got no response");
    end
    rdata = slave_resp.rdata;
  endtask

  function automatic step_t make_step(input logic [2:0] kind, input logic [1:0] op,
                                      input dmi_addr_t addr, input word_t wdata,
                                      input word_t exp, input word_t mask);
    return '{kind: kind, op: op, addr: addr, wdata: wdata, exp: exp, mask: mask};
  endfunction

  initial begin
    step_t s;
    word_t rd;
    logic [1:0] rop;
    logic [40:0] dout;

    clk = 1'b0;
    reset = 1'b1;
    tck = 1'b0;
    tms = 1'b1;
    tdi = 1'b0;
    slave_req = '0;
    master_resp = '0;
    rvalid_pending = 1'b0;
    rdata_pending = '0;
    wait_cnt = 0;
    grant_delay = 0;
    errors = 0;
    checks = 0;
    for (int i = 0; i < 16; i++) mem[i] = fill_word(i);

    // Registers, then halt and reset requests.
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DATA0, 32'h12345678, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_DATA0, 0, 32'h12345678, '1));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_HARTINFO, 0, 32'h00211000, '1));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_DMSTATUS, 0, 32'h00000082, 32'h8f));
    steps.push_back(make_step(K_DMI, DMI_READ, 7'h20, 0, 32'h0, '1));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DMCONTROL, 32'h80000001, 0, 0));
    steps.push_back(make_step(K_PINS, 0, 0, 0, 32'h3, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DMCONTROL, 32'h00000001, 0, 0));
    steps.push_back(make_step(K_PINS, 0, 0, 0, 32'h2, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DMCONTROL, 32'h00000003, 0, 0));
    steps.push_back(make_step(K_PINS, 0, 0, 0, 32'h0, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DMCONTROL, 32'h00000001, 0, 0));
    steps.push_back(make_step(K_PINS, 0, 0, 0, 32'h2, 0));
    // Bus writes with autoincrement.
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBCS, 32'h00010000, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBADDRESS0, 32'h00000010, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBDATA0, 32'hcafef00d, 0, 0));
    steps.push_back(make_step(K_POLL, 0, 0, 0, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBDATA0, 32'h0badbeef, 0, 0));
    steps.push_back(make_step(K_POLL, 0, 0, 0, 0, 0));
    steps.push_back(make_step(K_MEM, 0, 0, 32'd4, 32'hcafef00d, '1));
    steps.push_back(make_step(K_MEM, 0, 0, 32'd5, 32'h0badbeef, '1));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_SBADDRESS0, 0, 32'h00000018, '1));
    // Bus read started by the address write.
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBCS, 32'h00100000, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_SBADDRESS0, 32'h00000020, 0, 0));
    steps.push_back(make_step(K_POLL, 0, 0, 0, 0, 0));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_SBDATA0, 0, fill_word(8), '1));
    // Core data window.
    steps.push_back(make_step(K_CORE_WR, 0, 0, 32'h55aa33cc, 0, 32'hf));
    steps.push_back(make_step(K_DMI, DMI_READ, ADDR_DATA0, 0, 32'h55aa33cc, '1));
    steps.push_back(make_step(K_DMI, DMI_WRITE, ADDR_DATA0, 32'h0f1e2d3c, 0, 0));
    steps.push_back(make_step(K_CORE_RD, 0, 0, 0, 32'h0f1e2d3c, '1));
    steps.push_back(make_step(K_CORE_WR, 0, 0, 32'h000000ff, 0, 32'h1));
    steps.push_back(make_step(K_CORE_RD, 0, 0, 0, 32'h0f1e2dff, '1));

    repeat (10) @(negedge clk);
    reset = 1'b0;
    wait_pins(2'b10);

    tap_reset();
    dr_scan(32, 41'h0, dout);
    check_value("IDCODE", TB_IDCODE, dout[31:0], '1);
    ir_scan(5'h10);
    dr_scan(32, 41'h0, dout);
    check_value("DTMCS version", 32'h1, {28'b0, dout[3:0]}, '1);
    check_value("DTMCS abits", 32'h7, {26'b0, dout[9:4]}, '1);
    ir_scan(5'h11);

    foreach (steps[i]) begin
      s = steps[i];
      case (s.kind)
        K_DMI: begin
          if (s.op == DMI_WRITE) begin
            dmi_write(s.addr, s.wdata);
          end else begin
            dmi_read(s.addr, rd, rop);
            check_value($sformatf("DMI op at 0x%02h", s.addr), 32'h0, {30'b0, rop}, '1);
            check_value($sformatf("DMI data at 0x%02h", s.addr), s.exp, rd, s.mask);
          end
        end
        K_PINS:    wait_pins(s.exp[1:0]);
        K_POLL:    poll_sbbusy();
        K_MEM:     check_value($sformatf("mem[%0d]", s.wdata), s.exp, mem[s.wdata[3:0]], s.mask);
        K_CORE_WR: core_access(1'b1, s.mask[3:0], s.wdata, rd);
        K_CORE_RD: begin
          core_access(1'b0, 4'h0, 32'h0, rd);
          check_value("debug_slave_resp_o.rdata", s.exp, rd, s.mask);
        end
        default: begin
          errors++;
          $display("Unknown step kind %0d in the table", s.kind);
        end
      endcase
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/debug_subsystem.sv */
/*
 * Debug subsystem top. Joins the JTAG TAP, the debug module registers and
 * the system bus master, and exposes the core and OBI ports.
 */
`timescale 1ns/1ps
`default_nettype none

module debug_subsystem
  import debug_pkg::*;
#(
  parameter word_t jtag_idcode = 32'h10001c05
) (
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      jtag_tck_i,
  input  logic      jtag_tms_i,
  input  logic      jtag_tdi_i,
  output logic      jtag_tdo_o,

  output logic      debug_ndmreset_no,
  output logic      debug_core_req_o,

  input  obi_req_t  debug_slave_req_i,
  output obi_resp_t debug_slave_resp_o,
  output obi_req_t  debug_master_req_o,
  input  obi_resp_t debug_master_resp_i
);

  dmi_req_t  dmi_req;
  logic      dmi_req_valid;
  dmi_resp_t dmi_resp;
  logic      dmi_resp_valid;
  sba_cmd_t  sba_cmd;
  sba_rsp_t  sba_rsp;
  logic      ndmreset;

  assign debug_ndmreset_no = ~ndmreset;  // Active-low toward the system.

  jtag_tap #(
    .jtag_idcode(jtag_idcode)
  ) jtag_tap_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .tck_i           (jtag_tck_i),
    .tms_i           (jtag_tms_i),
    .tdi_i           (jtag_tdi_i),
    .tdo_o           (jtag_tdo_o),
    .dmi_req_o       (dmi_req),
    .dmi_req_valid_o (dmi_req_valid),
    .dmi_resp_i      (dmi_resp),
    .dmi_resp_valid_i(dmi_resp_valid)
  );

  dm_regs dm_regs_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .dmi_req_i       (dmi_req),
    .dmi_req_valid_i (dmi_req_valid),
    .dmi_resp_o      (dmi_resp),
    .dmi_resp_valid_o(dmi_resp_valid),
    .slave_req_i     (debug_slave_req_i),
    .slave_resp_o    (debug_slave_resp_o),
    .sba_cmd_o       (sba_cmd),
    .sba_rsp_i       (sba_rsp),
    .debug_req_o     (debug_core_req_o),
    .ndmreset_o      (ndmreset)
  );

  sba_obi_master sba_obi_master_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .sba_cmd_i (sba_cmd),
    .sba_rsp_o (sba_rsp),
    .obi_req_o (debug_master_req_o),
    .obi_resp_i(debug_master_resp_i)
  );

endmodule

`default_nettype wire

/* logic/sba_obi_master.sv */
/*
 * System bus access engine. Runs one 32-bit OBI master transaction per
 * command and reports completion with the read data.
 */
`timescale 1ns/1ps
`default_nettype none

module sba_obi_master
  import debug_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  sba_cmd_t  sba_cmd_i,
  output sba_rsp_t  sba_rsp_o,
  output obi_req_t  obi_req_o,
  input  obi_resp_t obi_resp_i
);

  typedef enum logic [1:0] {
    SBA_IDLE,
    SBA_REQ,
    SBA_WAIT
  } sba_state_t;

  sba_state_t state_q, state_d;
  logic       we_q;
  word_t      addr_q, wdata_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      SBA_IDLE: begin
        if (sba_cmd_i.valid) begin
          state_d = SBA_REQ;
        end
      end
      SBA_REQ: begin
        if (obi_resp_i.gnt) begin
          state_d = SBA_WAIT;
        end
      end
      SBA_WAIT: begin
        if (obi_resp_i.rvalid) begin
          state_d = SBA_IDLE;
        end
      end
      default: state_d = SBA_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SBA_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Fields are latched once and held through the grant.
  always_ff @(posedge clk_i) begin
    if (state_q == SBA_IDLE && sba_cmd_i.valid) begin
      we_q    <= sba_cmd_i.we;
      addr_q  <= sba_cmd_i.addr;
      wdata_q <= sba_cmd_i.wdata;
    end
  end

  assign obi_req_o = '{
    req:   (state_q == SBA_REQ),
    we:    we_q,
    be:    4'hf,  // Word accesses only.
    addr:  addr_q,
    wdata: wdata_q
  };

  assign sba_rsp_o = '{done: (state_q == SBA_WAIT) && obi_resp_i.rvalid,
                       rdata: obi_resp_i.rdata};

  a_addr_stable : assert property (@(posedge clk_i) disable iff (reset_i)
    obi_req_o.req && !obi_resp_i.gnt |=> obi_req_o.req && $stable(obi_req_o.addr))
    else $error("OBI master request changed before grant");

endmodule

`default_nettype wire

/* logic/dm_regs.sv */
/*
 * Debug module registers. Decodes DMI accesses, drives halt and reset
 * requests, serves data0 to the core over OBI and launches bus accesses.
 */
`timescale 1ns/1ps
`default_nettype none

module dm_regs
  import debug_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  dmi_req_t  dmi_req_i,
  input  logic      dmi_req_valid_i,
  output dmi_resp_t dmi_resp_o,
  output logic      dmi_resp_valid_o,
  input  obi_req_t  slave_req_i,
  output obi_resp_t slave_resp_o,
  output sba_cmd_t  sba_cmd_o,
  input  sba_rsp_t  sba_rsp_i,
  output logic      debug_req_o,
  output logic      ndmreset_o
);

  logic  dmactive_q, ndmreset_q, haltreq_q;
  logic  sbreadonaddr_q, sbautoinc_q, sbreadondata_q, sbbusy_q;
  word_t data0_q, sbaddress_q, sbdata_q;
  word_t data0_merged, rdata, dmstatus, sbcs;

  logic  req_read, req_write, sba_blocked;
  logic  wr_dmcontrol, wr_data0, wr_sbcs, wr_sbaddress, wr_sbdata, rd_sbdata;
  logic  sba_launch;

  logic    resp_valid_q;
  word_t   resp_data_q;
  dmi_op_t resp_op_q;
  logic    slave_rvalid_q;
  word_t   slave_rdata_q;
  logic    sba_valid_q, sba_we_q;
  word_t   sba_addr_q, sba_wdata_q;

  assign req_read    = dmi_req_valid_i && (dmi_req_i.op == DMI_READ);
  assign req_write   = dmi_req_valid_i && (dmi_req_i.op == DMI_WRITE);
  // A running bus access locks the registers it depends on.
  assign sba_blocked = sbbusy_q &&
                       (dmi_req_i.addr == ADDR_SBDATA0 || dmi_req_i.addr == ADDR_SBADDRESS0);

  assign wr_dmcontrol = req_write && (dmi_req_i.addr == ADDR_DMCONTROL);
  assign wr_data0     = req_write && (dmi_req_i.addr == ADDR_DATA0);
  assign wr_sbcs      = req_write && (dmi_req_i.addr == ADDR_SBCS);
  assign wr_sbaddress = req_write && (dmi_req_i.addr == ADDR_SBADDRESS0) && !sba_blocked;
  assign wr_sbdata    = req_write && (dmi_req_i.addr == ADDR_SBDATA0) && !sba_blocked;
  assign rd_sbdata    = req_read && (dmi_req_i.addr == ADDR_SBDATA0) && !sba_blocked;

  assign sba_launch = wr_sbdata || (wr_sbaddress && sbreadonaddr_q) ||
                      (rd_sbdata && sbreadondata_q);

  assign debug_req_o = haltreq_q & dmactive_q;
  assign ndmreset_o  = ndmreset_q;

  // The hart counts as halted as soon as the halt request is up.
  assign dmstatus = {20'b0, ~debug_req_o, ~debug_req_o, debug_req_o, debug_req_o,
                     1'b1, 3'b000, DMSTATUS_VERSION};
  assign sbcs = {3'd1, 6'b0, 1'b0, sbbusy_q, sbreadonaddr_q, 3'd2, sbautoinc_q,
                 sbreadondata_q, 3'b000, 7'd32, 5'b00100};

  always_comb begin
    case (dmi_req_i.addr)
      ADDR_DATA0:      rdata = data0_q;
      ADDR_DMCONTROL:  rdata = {haltreq_q, 29'b0, ndmreset_q, dmactive_q};
      ADDR_DMSTATUS:   rdata = dmstatus;
      ADDR_HARTINFO:   rdata = HARTINFO_VALUE;
      ADDR_SBCS:       rdata = sbcs;
      ADDR_SBADDRESS0: rdata = sbaddress_q;
      ADDR_SBDATA0:    rdata = sbdata_q;
      default:         rdata = '0;
    endcase
  end

  always_comb begin
    data0_merged = data0_q;
    for (int b = 0; b < 4; b++) begin
      if (slave_req_i.be[b]) begin
        data0_merged[8*b +: 8] = slave_req_i.wdata[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dmactive_q     <= 1'b0;
      ndmreset_q     <= 1'b0;
      haltreq_q      <= 1'b0;
      sbreadonaddr_q <= 1'b0;
      sbautoinc_q    <= 1'b0;
      sbreadondata_q <= 1'b0;
      sbbusy_q       <= 1'b0;
      resp_valid_q   <= 1'b0;
      slave_rvalid_q <= 1'b0;
      sba_valid_q    <= 1'b0;
    end else begin
      resp_valid_q   <= dmi_req_valid_i;
      slave_rvalid_q <= slave_req_i.req;
      sba_valid_q    <= sba_launch;
      if (wr_dmcontrol) begin
        dmactive_q <= dmi_req_i.data[0];
        ndmreset_q <= dmi_req_i.data[0] & dmi_req_i.data[1];  // dmactive low clears the DM.
        haltreq_q  <= dmi_req_i.data[0] & dmi_req_i.data[31];
      end
      if (wr_sbcs) begin
        sbreadonaddr_q <= dmi_req_i.data[20];
        sbautoinc_q    <= dmi_req_i.data[16];
        sbreadondata_q <= dmi_req_i.data[15];
      end
      if (sba_launch) begin
        sbbusy_q <= 1'b1;
      end else if (sba_rsp_i.done) begin
        sbbusy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    resp_data_q   <= rdata;
    resp_op_q     <= sba_blocked ? DMI_BUSY : DMI_OK;
    slave_rdata_q <= data0_q;
    if (wr_data0) begin
      data0_q <= dmi_req_i.data;
    end else if (slave_req_i.req && slave_req_i.we) begin
      data0_q <= data0_merged;
    end
    if (wr_sbaddress) begin
      sbaddress_q <= dmi_req_i.data;
    end else if (sba_rsp_i.done && sbautoinc_q) begin
      sbaddress_q <= sbaddress_q + 32'd4;
    end
    if (wr_sbdata) begin
      sbdata_q <= dmi_req_i.data;
    end else if (sba_rsp_i.done && !sba_we_q) begin
      sbdata_q <= sba_rsp_i.rdata;
    end
    if (sba_launch) begin
      sba_we_q    <= wr_sbdata;
      sba_addr_q  <= wr_sbaddress ? dmi_req_i.data : sbaddress_q;
      sba_wdata_q <= dmi_req_i.data;
    end
  end

  assign dmi_resp_o       = '{data: resp_data_q, op: resp_op_q};
  assign dmi_resp_valid_o = resp_valid_q;
  assign slave_resp_o     = '{gnt: slave_req_i.req, rvalid: slave_rvalid_q, rdata: slave_rdata_q};
  assign sba_cmd_o        = '{valid: sba_valid_q, we: sba_we_q, addr: sba_addr_q,
                              wdata: sba_wdata_q};

  a_no_cmd_when_busy : assert property (@(posedge clk_i) disable iff (reset_i)
    sba_cmd_o.valid |-> !$past(sbbusy_q))
    else $error("SBA command issued while sbbusy was set");

  a_slave_rvalid : assert property (@(posedge clk_i) disable iff (reset_i)
    slave_req_i.req && slave_resp_o.gnt |=> slave_resp_o.rvalid)
    else $error("OBI slave rvalid missing after grant");

endmodule

`default_nettype wire

/* logic/jtag_tap.sv */
/*
 * JTAG TAP oversampled in the system clock. Provides IDCODE, DTMCS and the
 * 41-bit DMI chain that turns scans into debug module register requests.
 */
`timescale 1ns/1ps
`default_nettype none

module jtag_tap
  import debug_pkg::*;
#(
  parameter word_t jtag_idcode = 32'h10001c05
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      tck_i,
  input  logic      tms_i,
  input  logic      tdi_i,
  output logic      tdo_o,
  output dmi_req_t  dmi_req_o,
  output logic      dmi_req_valid_o,
  input  dmi_resp_t dmi_resp_i,
  input  logic      dmi_resp_valid_i
);

  localparam logic [4:0] IR_IDCODE = 5'h01;
  localparam logic [4:0] IR_DTMCS  = 5'h10;
  localparam logic [4:0] IR_DMI    = 5'h11;

  // Idle hint 1, abits 7, version 1 (0.13).
  localparam word_t DTMCS_VALUE = {17'b0, 3'd1, 2'b00, 6'd7, 4'd1};

  logic [1:0] tck_sync_q, tms_sync_q, tdi_sync_q;
  logic       tck_prev_q;
  logic       tck_rise, tck_fall, tms, tdi;

  tap_state_t  state_q, state_d;
  logic [4:0]  ir_q, ir_shift_q;
  logic [40:0] dr_q;
  logic        tdo_q;
  dmi_req_t    dmi_req_q;
  logic        dmi_req_valid_q;
  dmi_resp_t   resp_q;
  logic        resp_seen_q;
  dmi_op_t     captured_op;
  logic        dmi_issue;

  assign tck_rise = tck_sync_q[1] & ~tck_prev_q;
  assign tck_fall = ~tck_sync_q[1] & tck_prev_q;
  assign tms      = tms_sync_q[1];
  assign tdi      = tdi_sync_q[1];

  assign captured_op = resp_seen_q ? resp_q.op : DMI_BUSY;  // No answer yet reads as busy.
  assign dmi_issue   = tck_rise && (state_q == TAP_UPDATE_DR) && (ir_q == IR_DMI) &&
                       ((dr_q[1:0] == DMI_READ) || (dr_q[1:0] == DMI_WRITE));

  always_comb begin
    case (state_q)
      TAP_RESET:      state_d = tms ? TAP_RESET     : TAP_IDLE;
      TAP_IDLE:       state_d = tms ? TAP_SELECT_DR : TAP_IDLE;
      TAP_SELECT_DR:  state_d = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR: state_d = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_SHIFT_DR:   state_d = tms ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_EXIT1_DR:   state_d = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:   state_d = tms ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
      TAP_EXIT2_DR:   state_d = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:  state_d = tms ? TAP_SELECT_DR : TAP_IDLE;
      TAP_SELECT_IR:  state_d = tms ? TAP_RESET     : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR: state_d = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_SHIFT_IR:   state_d = tms ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_EXIT1_IR:   state_d = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:   state_d = tms ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
      TAP_EXIT2_IR:   state_d = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      default:        state_d = tms ? TAP_SELECT_DR : TAP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tck_sync_q      <= '0;
      tms_sync_q      <= '0;
      tdi_sync_q      <= '0;
      tck_prev_q      <= 1'b0;
      state_q         <= TAP_RESET;
      ir_q            <= IR_IDCODE;
      tdo_q           <= 1'b0;
      dmi_req_valid_q <= 1'b0;
      resp_seen_q     <= 1'b0;
    end else begin
      tck_sync_q      <= {tck_sync_q[0], tck_i};
      tms_sync_q      <= {tms_sync_q[0], tms_i};
      tdi_sync_q      <= {tdi_sync_q[0], tdi_i};
      tck_prev_q      <= tck_sync_q[1];
      dmi_req_valid_q <= dmi_issue;
      if (tck_rise) begin
        state_q <= state_d;
      end
      if (state_q == TAP_RESET) begin
        ir_q <= IR_IDCODE;
      end else if (tck_rise && state_q == TAP_UPDATE_IR) begin
        ir_q <= ir_shift_q;
      end
      if (tck_fall) begin  // TDO moves on the falling edge only.
        tdo_q <= (state_q == TAP_SHIFT_DR) ? dr_q[0] :
                 (state_q == TAP_SHIFT_IR) ? ir_shift_q[0] : 1'b0;
      end
      if (dmi_issue) begin
        resp_seen_q <= 1'b0;
      end else if (dmi_resp_valid_i) begin
        resp_seen_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        TAP_CAPTURE_IR: ir_shift_q <= 5'b00001;
        TAP_SHIFT_IR:   ir_shift_q <= {tdi, ir_shift_q[4:1]};
        TAP_CAPTURE_DR: begin
          case (ir_q)
            IR_IDCODE: dr_q <= {9'b0, jtag_idcode};
            IR_DTMCS:  dr_q <= {9'b0, DTMCS_VALUE};
            IR_DMI:    dr_q <= {dmi_req_q.addr, resp_q.data, captured_op};
            default:   dr_q <= '0;
          endcase
        end
        TAP_SHIFT_DR: begin
          case (ir_q)
            IR_DMI:              dr_q <= {tdi, dr_q[40:1]};
            IR_IDCODE, IR_DTMCS: dr_q <= {9'b0, tdi, dr_q[31:1]};
            default:             dr_q <= {40'b0, tdi};  // Bypass.
          endcase
        end
        default: ;
      endcase
    end
    if (dmi_issue) begin
      dmi_req_q <= dr_q;
    end
    if (dmi_resp_valid_i) begin
      resp_q <= dmi_resp_i;
    end
  end

  assign tdo_o           = tdo_q;
  assign dmi_req_o       = dmi_req_q;
  assign dmi_req_valid_o = dmi_req_valid_q;

  a_req_single_pulse : assert property (@(posedge clk_i) disable iff (reset_i)
    dmi_req_valid_o |=> !dmi_req_valid_o)
    else $error("DMI request valid held for more than one cycle");

  a_reset_state : assert property (@(posedge clk_i) reset_i |=> state_q == TAP_RESET)
    else $error("TAP not in Test-Logic-Reset after reset");

endmodule

`default_nettype wire

/* logic/debug_pkg.sv */
/*
 * Debug subsystem shared types. Covers DMI and OBI transfers, the SBA handshake,
 * the TAP states and the debug module register map.
 */
`default_nettype none

package debug_pkg;

  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] word_t;

  // Responses reuse the request encoding. BUSY is code 3.
  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2,
    DMI_BUSY  = 2'd3
  } dmi_op_t;

  localparam dmi_op_t DMI_OK     = DMI_NOP;
  localparam dmi_op_t DMI_FAILED = DMI_WRITE;

  typedef struct packed {
    dmi_addr_t addr;
    word_t     data;
    dmi_op_t   op;
  } dmi_req_t;

  typedef struct packed {
    word_t   data;
    dmi_op_t op;
  } dmi_resp_t;

  typedef struct packed {
    logic       req;
    logic       we;
    logic [3:0] be;
    word_t      addr;
    word_t      wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } obi_resp_t;

  typedef struct packed {
    logic  valid;
    logic  we;
    word_t addr;
    word_t wdata;
  } sba_cmd_t;

  typedef struct packed {
    logic  done;
    word_t rdata;
  } sba_rsp_t;

  typedef enum logic [3:0] {
    TAP_RESET, TAP_IDLE,
    TAP_SELECT_DR, TAP_CAPTURE_DR, TAP_SHIFT_DR, TAP_EXIT1_DR,
    TAP_PAUSE_DR, TAP_EXIT2_DR, TAP_UPDATE_DR,
    TAP_SELECT_IR, TAP_CAPTURE_IR, TAP_SHIFT_IR, TAP_EXIT1_IR,
    TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPDATE_IR
  } tap_state_t;

  localparam dmi_addr_t ADDR_DATA0      = 7'h04;
  localparam dmi_addr_t ADDR_DMCONTROL  = 7'h10;
  localparam dmi_addr_t ADDR_DMSTATUS   = 7'h11;
  localparam dmi_addr_t ADDR_HARTINFO   = 7'h12;
  localparam dmi_addr_t ADDR_SBCS       = 7'h38;
  localparam dmi_addr_t ADDR_SBADDRESS0 = 7'h39;
  localparam dmi_addr_t ADDR_SBDATA0    = 7'h3c;

  // nscratch 2, dataaccess 1, datasize 1, dataaddr 0.
  localparam word_t HARTINFO_VALUE = {8'h00, 4'd2, 3'b000, 1'b1, 4'd1, 12'h000};

  localparam logic [3:0] DMSTATUS_VERSION = 4'd2;

endpackage

`default_nettype wire
